// ==== ifetch_sys.f ====
logic/ifetch_pkg.sv
logic/inst_mem.sv
logic/imem_arbiter.sv
logic/prog_loader.sv
logic/ifetch_unit.sv
logic/ifetch_top.sv
verif/clk_gen.sv
verif/ifetch_properties.sv
verif/ifetch_tb.sv

// ==== Bender.yml ====
package:
  name: ifetch_sys

sources:
  # Design
  - files:
      - logic/ifetch_pkg.sv
      - logic/inst_mem.sv
      - logic/imem_arbiter.sv
      - logic/prog_loader.sv
      - logic/ifetch_unit.sv
      - logic/ifetch_top.sv

  # Verification
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/ifetch_properties.sv
      - verif/ifetch_tb.sv

// ==== verif/ifetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb;

   localparam int IMEM_ADDR_W = 14;
   localparam int PROG_WORDS  = 16;
   localparam int WAIT_LIMIT  = 20;

   wire clk;
   wire rstn;

   // DUT inputs
   logic              pause_i, branch_i, zero_i, jump_i, jalr_i;
   ifetch_pkg::addr_t branch_pc_i, imm_i, alu_result_i;
   logic              load_start_i, byte_valid_i, load_end_i;
   ifetch_pkg::byte_t byte_i;
   // DUT outputs
   ifetch_pkg::inst_t inst_o;
   ifetch_pkg::addr_t pc_o, pc_plus4_o;
   logic              inst_valid_o, flush_o, busy_o;

   // Expected RAM image, little-endian words as uploaded
   ifetch_pkg::inst_t model_mem [PROG_WORDS];
   integer            seed = 32'hb92c_acf7;
   int unsigned       check_errors = 0;
   int unsigned       timeout_errors = 0;
   string             test_name = "reset";
   logic              load_blocked = 1'b0;

   clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clk_gen_inst (.clk_o(clk), .rstn_o(rstn));

   ifetch_top #(.IMEM_ADDR_W(IMEM_ADDR_W)) ifetch_top_inst (
      .clk (clk), .rstn (rstn),
      .pause_i (pause_i), .branch_i (branch_i), .zero_i (zero_i),
      .jump_i (jump_i), .jalr_i (jalr_i), .branch_pc_i (branch_pc_i),
      .imm_i (imm_i), .alu_result_i (alu_result_i),
      .load_start_i (load_start_i), .byte_valid_i (byte_valid_i),
      .byte_i (byte_i), .load_end_i (load_end_i),
      .inst_o (inst_o), .pc_o (pc_o), .pc_plus4_o (pc_plus4_o),
      .inst_valid_o (inst_valid_o), .flush_o (flush_o), .busy_o (busy_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_fail(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
      check_errors++;
   endtask

   // Drive point, just after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic await_valid();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (inst_valid_o !== 1'b1 && n < WAIT_LIMIT);
      if (inst_valid_o !== 1'b1) begin
         $display("Timed out waiting for a valid instruction in test %s", test_name);
         timeout_errors++;
      end
   endtask

   task automatic check_idle();
      assert (inst_valid_o === 1'b0) else report_fail("inst_valid_o", 0, inst_valid_o);
      assert (flush_o === 1'b0) else report_fail("flush_o", 0, flush_o);
      assert (busy_o === 1'b0) else report_fail("busy_o", 0, busy_o);
      assert (pc_o === ifetch_pkg::RESET_VECTOR)
         else report_fail("pc_o", ifetch_pkg::RESET_VECTOR, pc_o);
   endtask

   task automatic send_byte(input ifetch_pkg::byte_t value);
      // Random idle gap before some strobes
      if ($random(seed) & 1) next_cycle();
      byte_valid_i = 1'b1;
      byte_i       = value;
      next_cycle();
      byte_valid_i = 1'b0;
   endtask

   // Full words first, then a dangling partial word
   task automatic upload_program(input int extra_bytes);
      ifetch_pkg::inst_t word;
      for (int w = 0; w < PROG_WORDS; w++) begin
         word         = $random(seed);
         model_mem[w] = word;
         for (int b = 0; b < 4; b++) send_byte(word[8*b +: 8]);
      end
      for (int b = 0; b < extra_bytes; b++) send_byte($random(seed));
   endtask

   task automatic pulse_start();
      load_start_i = 1'b1;
      next_cycle();
      load_start_i = 1'b0;
   endtask

   task automatic pulse_end();
      load_end_i = 1'b1;
      next_cycle();
      load_end_i = 1'b0;
   endtask

   // Targets kept inside the loaded image
   task automatic pick_target();
      branch_pc_i = 32'd16 + (($random(seed) & 3) << 2);
      imm_i       = (($random(seed) & 7) << 2) - 32'd16;
   endtask

   task automatic check_redirect(input ifetch_pkg::addr_t target);
      @(negedge clk);
      assert (flush_o === 1'b1) else report_fail("flush_o", 1, flush_o);
      next_cycle();
      {branch_i, zero_i, jump_i, jalr_i} = 4'b0000;
      await_valid();
      assert (pc_o === target) else report_fail("pc_o", target, pc_o);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Monitor, every valid word against the model
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (rstn === 1'b1 && inst_valid_o === 1'b1) begin
         assert (pc_plus4_o === pc_o + 32'd4)
            else report_fail("pc_plus4_o", pc_o + 32'd4, pc_plus4_o);
         if (pc_o < PROG_WORDS * 4) begin
            assert (inst_o === model_mem[pc_o >> 2])
               else report_fail("inst_o", model_mem[pc_o >> 2], inst_o);
         end
      end
      if (load_blocked) begin
         assert (inst_valid_o === 1'b0) else report_fail("inst_valid_o", 0, inst_valid_o);
         assert (busy_o === 1'b1) else report_fail("busy_o", 1, busy_o);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      ifetch_pkg::addr_t held_pc;
      ifetch_pkg::addr_t seq_pc;
      ifetch_pkg::inst_t held_inst;
      int unsigned       prop_errors;
      int                n;
      // Fetch held off until a program is in
      pause_i = 1'b1;
      {branch_i, zero_i, jump_i, jalr_i} = 4'b0000;
      branch_pc_i  = '0;
      imm_i        = '0;
      alu_result_i = '0;
      {load_start_i, byte_valid_i, load_end_i} = 3'b000;
      byte_i = '0;

      n = 0;
      while (rstn !== 1'b1 && n < 10) begin
         @(negedge clk);
         check_idle();
         n++;
      end
      if (rstn !== 1'b1) begin
         $display("Timed out waiting for reset release");
         timeout_errors++;
      end
      repeat (2) begin
         @(negedge clk);
         check_idle();
      end

      test_name = "load_seq";
      next_cycle();
      pulse_start();
      upload_program(0);
      pulse_end();
      pause_i = 1'b0;
      await_valid();
      assert (pc_o === ifetch_pkg::RESET_VECTOR)
         else report_fail("first pc_o", ifetch_pkg::RESET_VECTOR, pc_o);
      repeat (8) @(negedge clk);

      test_name = "pause";
      next_cycle();
      pause_i = 1'b1;
      @(negedge clk);
      held_pc   = pc_o;
      held_inst = inst_o;
      repeat (4) begin
         @(negedge clk);
         assert (pc_o === held_pc) else report_fail("pc_o", held_pc, pc_o);
         assert (inst_o === held_inst) else report_fail("inst_o", held_inst, inst_o);
      end
      next_cycle();
      pause_i = 1'b0;

      test_name = "branch";
      next_cycle();
      {branch_i, zero_i} = 2'b11;
      pick_target();
      check_redirect(branch_pc_i + imm_i);

      test_name = "jump";
      next_cycle();
      jump_i = 1'b1;
      pick_target();
      check_redirect(branch_pc_i + imm_i);

      // Zero low, branch falls through
      test_name = "branch_not_taken";
      next_cycle();
      branch_i = 1'b1;
      @(negedge clk);
      seq_pc = pc_o + 32'd4;
      assert (flush_o === 1'b0) else report_fail("flush_o", 0, flush_o);
      next_cycle();
      branch_i = 1'b0;
      await_valid();
      assert (pc_o === seq_pc) else report_fail("pc_o", seq_pc, pc_o);

      test_name = "jalr";
      next_cycle();
      jalr_i       = 1'b1;
      alu_result_i = 32'd8 + (($random(seed) & 7) << 2);
      check_redirect(alu_result_i);

      // Jump wins over jalr
      test_name = "jalr_jump";
      next_cycle();
      {jump_i, jalr_i} = 2'b11;
      alu_result_i     = 32'd60;
      pick_target();
      check_redirect(branch_pc_i + imm_i);

      test_name = "load_block";
      next_cycle();
      send_byte(8'ha5);
      pulse_start();
      next_cycle();
      load_blocked = 1'b1;
      upload_program(2);
      pulse_end();
      load_blocked = 1'b0;
      await_valid();
      assert (pc_o === ifetch_pkg::RESET_VECTOR)
         else report_fail("pc_o", ifetch_pkg::RESET_VECTOR, pc_o);
      assert (inst_o === model_mem[0]) else report_fail("inst_o", model_mem[0], inst_o);

      next_cycle();
      prop_errors = ifetch_top_inst.ifetch_props_inst.fail_count;
      $display("Check errors %0d, timeouts %0d, assertion failures %0d",
               check_errors, timeout_errors, prop_errors);
      if (check_errors + timeout_errors + prop_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/ifetch_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch_properties (
   input wire                          clk,
   input wire                          rstn,
   input wire                          branch_i,
   input wire                          zero_i,
   input wire                          jump_i,
   input wire                          jalr_i,
   input wire                          flush_i,
   input wire                          busy_i,
   input wire                          fetch_grant_i,
   input wire                          mem_we_i,
   input wire ifetch_pkg::load_state_e load_state_i
);

   // Read by the testbench at the end of the run
   int unsigned fail_count = 0;

   // Loader write never lands on a granted fetch cycle
   no_write_on_grant: assert property (@(posedge clk) disable iff (!rstn)
      !(mem_we_i && fetch_grant_i))
      else begin
         $error("RAM write while fetch holds the grant");
         fail_count++;
      end

   // One owner of the RAM port at a time
   busy_excludes_grant: assert property (@(posedge clk) disable iff (!rstn)
      !(busy_i && fetch_grant_i))
      else begin
         $error("Loader busy and fetch granted together");
         fail_count++;
      end

   // Flush follows the redirect inputs, combinational
   flush_on_redirect: assert property (@(posedge clk) disable iff (!rstn)
      flush_i == ((branch_i && zero_i) || jump_i || jalr_i))
      else begin
         $error("Flush does not match the redirect condition");
         fail_count++;
      end

   // RAM writes only inside an upload session
   write_in_session: assert property (@(posedge clk) disable iff (!rstn)
      mem_we_i |-> (load_state_i == ifetch_pkg::LOAD_ACTIVE))
      else begin
         $error("RAM write outside an upload session");
         fail_count++;
      end

endmodule

bind ifetch_top ifetch_properties ifetch_props_inst (
   .clk           (clk),
   .rstn          (rstn),
   .branch_i      (branch_i),
   .zero_i        (zero_i),
   .jump_i        (jump_i),
   .jalr_i        (jalr_i),
   .flush_i       (flush_o),
   .busy_i        (busy_o),
   .fetch_grant_i (fetch_grant),
   .mem_we_i      (mem_we),
   .load_state_i  (prog_loader_inst.state_q)
);

`default_nettype wire

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic clk_o,
   output logic rstn_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release lines up with the stimulus drive point
   initial begin
      rstn_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #5;
      rstn_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== logic/ifetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch_top #(
   parameter int IMEM_ADDR_W = 14
) (
   input  wire                      clk,
   input  wire                      rstn,
   // Pipeline inputs
   input  wire                      pause_i,
   input  wire                      branch_i,
   input  wire                      zero_i,
   input  wire                      jump_i,
   input  wire                      jalr_i,
   input  wire ifetch_pkg::addr_t   branch_pc_i,
   input  wire ifetch_pkg::addr_t   imm_i,
   input  wire ifetch_pkg::addr_t   alu_result_i,
   // Upload inputs
   input  wire                      load_start_i,
   input  wire                      byte_valid_i,
   input  wire ifetch_pkg::byte_t   byte_i,
   input  wire                      load_end_i,
   // Fetch outputs
   output ifetch_pkg::inst_t        inst_o,
   output ifetch_pkg::addr_t        pc_o,
   output ifetch_pkg::addr_t        pc_plus4_o,
   output logic                     inst_valid_o,
   output logic                     flush_o,
   output logic                     busy_o
);

   // Fetch request path
   logic                   fetch_req;
   logic [IMEM_ADDR_W-1:0] fetch_addr;
   logic                   fetch_grant;
   // Loader write path
   logic                   load_done;
   logic                   wr_en;
   logic [IMEM_ADDR_W-1:0] wr_addr;
   ifetch_pkg::inst_t      wr_data;
   // RAM port
   logic                   mem_en;
   logic                   mem_we;
   logic [IMEM_ADDR_W-1:0] mem_addr;
   ifetch_pkg::inst_t      mem_wdata;
   ifetch_pkg::inst_t      mem_rdata;

   ////////////////////////////////////////////////////////////////////////////
   // Fetch unit
   ////////////////////////////////////////////////////////////////////////////

   ifetch_unit #(.IMEM_ADDR_W(IMEM_ADDR_W)) ifetch_unit_inst (
      .clk           (clk),
      .rstn          (rstn),
      .pause_i       (pause_i),
      .branch_i      (branch_i),
      .zero_i        (zero_i),
      .jump_i        (jump_i),
      .jalr_i        (jalr_i),
      .branch_pc_i   (branch_pc_i),
      .imm_i         (imm_i),
      .alu_result_i  (alu_result_i),
      .fetch_grant_i (fetch_grant),
      .restart_i     (load_done),
      .rdata_i       (mem_rdata),
      .fetch_req_o   (fetch_req),
      .fetch_addr_o  (fetch_addr),
      .inst_o        (inst_o),
      .pc_o          (pc_o),
      .pc_plus4_o    (pc_plus4_o),
      .inst_valid_o  (inst_valid_o),
      .flush_o       (flush_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Upload path and shared RAM
   ////////////////////////////////////////////////////////////////////////////

   prog_loader #(.IMEM_ADDR_W(IMEM_ADDR_W)) prog_loader_inst (
      .clk          (clk),
      .rstn         (rstn),
      .load_start_i (load_start_i),
      .byte_valid_i (byte_valid_i),
      .byte_i       (byte_i),
      .load_end_i   (load_end_i),
      .busy_o       (busy_o),
      .done_o       (load_done),
      .wr_en_o      (wr_en),
      .wr_addr_o    (wr_addr),
      .wr_data_o    (wr_data)
   );

   imem_arbiter #(.IMEM_ADDR_W(IMEM_ADDR_W)) imem_arbiter_inst (
      .clk           (clk),
      .rstn          (rstn),
      .loader_busy_i (busy_o),
      .wr_en_i       (wr_en),
      .wr_addr_i     (wr_addr),
      .wr_data_i     (wr_data),
      .fetch_req_i   (fetch_req),
      .fetch_addr_i  (fetch_addr),
      .fetch_grant_o (fetch_grant),
      .mem_en_o      (mem_en),
      .mem_we_o      (mem_we),
      .mem_addr_o    (mem_addr),
      .mem_wdata_o   (mem_wdata)
   );

   // Single-port instruction RAM
   inst_mem #(.IMEM_ADDR_W(IMEM_ADDR_W)) inst_mem_inst (
      .clk     (clk),
      .en_i    (mem_en),
      .we_i    (mem_we),
      .addr_i  (mem_addr),
      .wdata_i (mem_wdata),
      .rdata_o (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== logic/ifetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch_unit #(
   parameter int IMEM_ADDR_W = 14
) (
   input  wire                      clk,
   input  wire                      rstn,
   // Pipeline control
   input  wire                      pause_i,
   input  wire                      branch_i,
   input  wire                      zero_i,
   input  wire                      jump_i,
   input  wire                      jalr_i,
   input  wire ifetch_pkg::addr_t   branch_pc_i,
   input  wire ifetch_pkg::addr_t   imm_i,
   input  wire ifetch_pkg::addr_t   alu_result_i,
   // From arbiter and loader
   input  wire                      fetch_grant_i,
   input  wire                      restart_i,
   // RAM read data
   input  wire ifetch_pkg::inst_t   rdata_i,
   // RAM request
   output logic                     fetch_req_o,
   output logic [IMEM_ADDR_W-1:0]   fetch_addr_o,
   // Fetched word and its tag
   output ifetch_pkg::inst_t        inst_o,
   output ifetch_pkg::addr_t        pc_o,
   output ifetch_pkg::addr_t        pc_plus4_o,
   output logic                     inst_valid_o,
   output logic                     flush_o
);

   ifetch_pkg::addr_t pc_q;
   ifetch_pkg::addr_t next_pc;
   ifetch_pkg::addr_t target_pc;
   logic              take_target;
   logic              fetch_fire;

   ////////////////////////////////////////////////////////////////////////////
   // Next PC selection
   ////////////////////////////////////////////////////////////////////////////

   // Taken branch or unconditional jump
   assign take_target = (branch_i & zero_i) | jump_i;
   assign target_pc   = branch_pc_i + imm_i;

   // Branch/jump beats jalr, jalr beats sequential
   always_comb begin
      if (take_target) begin
         next_pc = target_pc;
      end else if (jalr_i) begin
         next_pc = alu_result_i;
      end else begin
         next_pc = pc_q + 32'd4;
      end
   end

   // Any redirect kills the word already in flight
   assign flush_o = take_target | jalr_i;

   // RAM request side
   assign fetch_req_o  = ~pause_i;
   assign fetch_addr_o = pc_q[IMEM_ADDR_W+1:2];
   // RAM actually reads for us this cycle
   assign fetch_fire   = fetch_req_o & fetch_grant_i;

   ////////////////////////////////////////////////////////////////////////////
   // PC register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         pc_q <= ifetch_pkg::RESET_VECTOR;
      end else if (restart_i) begin
         // Fresh program, start over
         pc_q <= ifetch_pkg::RESET_VECTOR;
      end else if (fetch_fire) begin
         pc_q <= next_pc;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output tag, aligned with the RAM read
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         pc_o         <= ifetch_pkg::RESET_VECTOR;
         inst_valid_o <= 1'b0;
      end else if (!fetch_grant_i) begin
         // Loader owns the RAM, nothing useful comes out
         inst_valid_o <= 1'b0;
      end else if (fetch_fire) begin
         pc_o         <= pc_q;
         // Wrong-path word on a redirect
         inst_valid_o <= ~flush_o & ~restart_i;
      end
   end

   // RAM output register already holds the word
   assign inst_o     = rdata_i;
   assign pc_plus4_o = pc_o + 32'd4;

endmodule

`default_nettype wire

// ==== logic/prog_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_loader #(
   parameter int IMEM_ADDR_W = 14
) (
   input  wire                      clk,
   input  wire                      rstn,
   // Upload side
   input  wire                      load_start_i,
   input  wire                      byte_valid_i,
   input  wire ifetch_pkg::byte_t   byte_i,
   input  wire                      load_end_i,
   // Session status
   output logic                     busy_o,
   output logic                     done_o,
   // RAM write port
   output logic                     wr_en_o,
   output logic [IMEM_ADDR_W-1:0]   wr_addr_o,
   output ifetch_pkg::inst_t        wr_data_o
);

   ifetch_pkg::load_state_e state_q;
   ifetch_pkg::load_state_e state_d;
   logic [1:0]              byte_cnt_q;
   ifetch_pkg::inst_t       shift_q;
   logic                    byte_take;

   ////////////////////////////////////////////////////////////////////////////
   // Session FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         ifetch_pkg::LOAD_IDLE: begin
            if (load_start_i) begin
               state_d = ifetch_pkg::LOAD_ACTIVE;
            end
         end
         ifetch_pkg::LOAD_ACTIVE: begin
            if (load_end_i) begin
               state_d = ifetch_pkg::LOAD_IDLE;
            end
         end
         default: state_d = ifetch_pkg::LOAD_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state_q <= ifetch_pkg::LOAD_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign busy_o = (state_q == ifetch_pkg::LOAD_ACTIVE);
   // High in the cycle whose edge ends the session
   assign done_o = busy_o & load_end_i;

   // Stray bytes outside a session go nowhere
   assign byte_take = busy_o & byte_valid_i;

   ////////////////////////////////////////////////////////////////////////////
   // Byte packing
   ////////////////////////////////////////////////////////////////////////////

   // Fourth byte completes the word, written straight away
   assign wr_en_o   = byte_take & (byte_cnt_q == 2'd3);
   // Little-endian, earliest byte lands in bits 7:0
   assign wr_data_o = {byte_i, shift_q[31:8]};

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         byte_cnt_q <= 2'd0;
         wr_addr_o  <= '0;
      end else if (load_start_i && !busy_o) begin
         // New session starts at word 0
         byte_cnt_q <= 2'd0;
         wr_addr_o  <= '0;
      end else if (load_end_i) begin
         // Partial word dropped
         byte_cnt_q <= 2'd0;
      end else if (byte_take) begin
         byte_cnt_q <= byte_cnt_q + 2'd1;
         if (wr_en_o) begin
            wr_addr_o <= wr_addr_o + 1'b1;
         end
      end
   end

   // Payload shift register
   always_ff @(posedge clk) begin
      if (byte_take) begin
         shift_q <= {byte_i, shift_q[31:8]};
      end
   end

endmodule

`default_nettype wire

// ==== logic/imem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_arbiter #(
   parameter int IMEM_ADDR_W = 14
) (
   input  wire                      clk,
   input  wire                      rstn,
   // Loader side
   input  wire                      loader_busy_i,
   input  wire                      wr_en_i,
   input  wire [IMEM_ADDR_W-1:0]    wr_addr_i,
   input  wire ifetch_pkg::inst_t   wr_data_i,
   // Fetch side
   input  wire                      fetch_req_i,
   input  wire [IMEM_ADDR_W-1:0]    fetch_addr_i,
   output logic                     fetch_grant_o,
   // RAM port
   output logic                     mem_en_o,
   output logic                     mem_we_o,
   output logic [IMEM_ADDR_W-1:0]   mem_addr_o,
   output ifetch_pkg::inst_t        mem_wdata_o
);

   logic owner_q;
   logic loader_owns;

   // Loader held the port last cycle
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         owner_q <= 1'b0;
      end else begin
         owner_q <= loader_busy_i;
      end
   end

   // Busy is registered in the loader, so ownership only moves at an edge
   // One guard cycle after the load before fetch gets the port back
   assign loader_owns   = loader_busy_i | owner_q;
   assign fetch_grant_o = ~loader_owns;

   ////////////////////////////////////////////////////////////////////////////
   // Port mux
   ////////////////////////////////////////////////////////////////////////////

   // RAM only runs for a write or a granted read
   assign mem_en_o    = loader_owns ? wr_en_i : fetch_req_i;
   assign mem_we_o    = loader_owns & wr_en_i;
   assign mem_addr_o  = loader_owns ? wr_addr_i : fetch_addr_i;
   assign mem_wdata_o = wr_data_i;

endmodule

`default_nettype wire

// ==== logic/inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_mem #(
   parameter int IMEM_ADDR_W = 14
) (
   input  wire                      clk,
   input  wire                      en_i,
   input  wire                      we_i,
   input  wire [IMEM_ADDR_W-1:0]    addr_i,
   input  wire ifetch_pkg::inst_t   wdata_i,
   output ifetch_pkg::inst_t        rdata_o
);

   localparam int DEPTH = 2 ** IMEM_ADDR_W;

   // Word storage
   ifetch_pkg::inst_t mem [DEPTH];

   ////////////////////////////////////////////////////////////////////////////
   // Single port, read-or-write per cycle
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (en_i) begin
         if (we_i) begin
            mem[addr_i] <= wdata_i;
         end else begin
            // Registered read, held while disabled
            rdata_o <= mem[addr_i];
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/ifetch_pkg.sv ====
`default_nettype none

package ifetch_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data widths
   ////////////////////////////////////////////////////////////////////////////

   // Byte address, also the PC
   typedef logic [31:0] addr_t;

   // One instruction word
   typedef logic [31:0] inst_t;

   // Upload byte from the host side
   typedef logic [7:0] byte_t;

   ////////////////////////////////////////////////////////////////////////////
   // Constants
   ////////////////////////////////////////////////////////////////////////////

   // PC after reset and after a program upload
   localparam addr_t RESET_VECTOR = 32'h0000_0000;

   ////////////////////////////////////////////////////////////////////////////
   // Loader FSM
   ////////////////////////////////////////////////////////////////////////////

   // Idle, or inside an upload session
   typedef enum logic {
      LOAD_IDLE   = 1'b0,
      LOAD_ACTIVE = 1'b1
   } load_state_e;

endpackage

`default_nettype wire
